/* common/quant_pkg.sv */
package quant_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int ACT_WIDTH   = 8;   // activation and weight operands
	localparam int PSUM_WIDTH  = 32;  // accumulator and partial sum
	localparam int OUT_WIDTH   = 16;  // selected result
	localparam int CMD_WIDTH   = 5;   // shift enable plus shift amount
	localparam int SHIFT_WIDTH = CMD_WIDTH - 1;

	//////////////////////////////////////////////////////////////////////
	// data words
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [ACT_WIDTH-1:0]  act_t;
	typedef logic signed [PSUM_WIDTH-1:0] psum_t;  // wraps modulo 2^32
	typedef logic [OUT_WIDTH-1:0]         qout_t;

	// operand pair of one lane for one beat
	typedef struct packed {
		act_t act;
		act_t wgt;
	} lane_in_t;

	//////////////////////////////////////////////////////////////////////
	// selection command
	//////////////////////////////////////////////////////////////////////

	// shift_en low keeps the low half of the sum
	// shift_en high takes 16 bits from offset shift_amt + 1
	typedef struct packed {
		logic                   shift_en;
		logic [SHIFT_WIDTH-1:0] shift_amt;
	} sel_cmd_t;

endpackage

/* verilog/mac_lane.sv */
`timescale 1ns/1ns

module mac_lane (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_valid,   // one beat of operands
	input  logic                i_last,    // final beat of the dot product
	input  quant_pkg::lane_in_t i_data,
	output logic                o_valid,   // pulses one cycle after the last beat
	output quant_pkg::psum_t    o_psum
);

	import quant_pkg::*;

	localparam int PROD_WIDTH = 2 * ACT_WIDTH;

	logic signed [PROD_WIDTH-1:0] prod;
	psum_t                        prod_ext;
	psum_t                        acc_q;     // running sum of earlier beats
	psum_t                        acc_sum;   // sum including this beat
	logic                         close_sum;

	//////////////////////////////////////////////////////////////////////
	// multiply and add
	//////////////////////////////////////////////////////////////////////

	// signed 8x8 product always fits in 16 bits
	assign prod = $signed(i_data.act) * $signed(i_data.wgt);

	// sign extension up to the accumulator width
	assign prod_ext = {{(PSUM_WIDTH - PROD_WIDTH){prod[PROD_WIDTH-1]}}, prod};

	assign acc_sum   = acc_q + prod_ext;  // overflow just wraps
	assign close_sum = i_valid & i_last;

	//////////////////////////////////////////////////////////////////////
	// accumulator and valid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			acc_q   <= '0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= close_sum;
			if (close_sum)
			begin
				// next dot product may start on the very next beat
				acc_q <= '0;
			end
			else if (i_valid)
			begin
				acc_q <= acc_sum;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// completed sum
	//////////////////////////////////////////////////////////////////////

	// held until the next last beat
	always_ff @(posedge clk)
	begin
		if (close_sum)
		begin
			o_psum <= acc_sum;
		end
	end

endmodule

/* bit_select/bit_select_32x16.sv */
`timescale 1ns/1ns

module bit_select_32x16 (
	input  logic                clk,
	input  logic                i_rst_n,
	input  logic                i_valid,  // partial sum valid
	input  logic                i_en,     // output stage enable
	input  quant_pkg::sel_cmd_t i_cmd,    // sampled together with i_valid
	input  quant_pkg::psum_t    i_data,
	output logic                o_valid,
	output quant_pkg::qout_t    o_data
);

	import quant_pkg::*;

	logic                 take;
	logic [SHIFT_WIDTH:0] offset;      // 1 to 16
	qout_t                plain_data;
	qout_t                shift_data;

	// plain path
	logic                 plain_valid_q;
	qout_t                plain_q;

	// shifted path
	logic                 shift_valid_q;
	qout_t                shift_q;

	logic                 shift_sel_q; // which path drives the outputs

	//////////////////////////////////////////////////////////////////////
	// candidate results
	//////////////////////////////////////////////////////////////////////

	assign take   = i_en & i_valid;
	assign offset = {1'b0, i_cmd.shift_amt} + 1'b1;

	assign plain_data = i_data[OUT_WIDTH-1:0];    // low half unchanged
	assign shift_data = i_data[offset +: OUT_WIDTH]; // top case reaches bit 31

	//////////////////////////////////////////////////////////////////////
	// plain path register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			plain_valid_q <= 1'b0;
			plain_q       <= '0;
		end
		else if (take && !i_cmd.shift_en)
		begin
			plain_valid_q <= 1'b1;
			plain_q       <= plain_data;
		end
		else
		begin
			plain_valid_q <= 1'b0;
			plain_q       <= '0;  // zero when idle
		end
	end

	//////////////////////////////////////////////////////////////////////
	// shifted path register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
		begin
			shift_valid_q <= 1'b0;
			shift_q       <= '0;
		end
		else if (take && i_cmd.shift_en)
		begin
			shift_valid_q <= 1'b1;
			shift_q       <= shift_data;
		end
		else
		begin
			shift_valid_q <= 1'b0;
			shift_q       <= '0;
		end
	end

	// path choice travels with the data
	always_ff @(posedge clk)
	begin
		if (!i_rst_n)
			shift_sel_q <= 1'b0;
		else
			shift_sel_q <= i_cmd.shift_en;
	end

	assign o_data  = shift_sel_q ? shift_q : plain_q;
	assign o_valid = shift_sel_q ? shift_valid_q : plain_valid_q;

endmodule

/* verilog/requant_top.sv */
`timescale 1ns/1ns

module requant_top #(
	parameter int LANES = 4
) (
	input  logic                            clk,
	input  logic                            i_rst_n,

	// beat control shared by all lanes
	input  logic                            i_valid,
	input  logic                            i_last,
	input  quant_pkg::lane_in_t [LANES-1:0] i_lane_data,

	// output stage control held as levels
	input  logic                            i_en,
	input  quant_pkg::sel_cmd_t             i_cmd,

	output logic                            o_valid,
	output quant_pkg::qout_t [LANES-1:0]    o_qdata
);

	import quant_pkg::*;

	psum_t [LANES-1:0] lane_psum;        // completed sums, one per lane
	logic  [LANES-1:0] lane_psum_valid;
	logic  [LANES-1:0] lane_out_valid;

	//////////////////////////////////////////////////////////////////////
	// lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar l = 0; l < LANES; l++)
	begin : g_lane

		// accumulate until the last beat
		mac_lane u_mac (
			.clk     (clk),
			.i_rst_n (i_rst_n),
			.i_valid (i_valid),
			.i_last  (i_last),
			.i_data  (i_lane_data[l]),
			.o_valid (lane_psum_valid[l]),
			.o_psum  (lane_psum[l])
		);

		// reduce the 32 bit sum to 16 bits in one more cycle
		bit_select_32x16 u_sel (
			.clk     (clk),
			.i_rst_n (i_rst_n),
			.i_valid (lane_psum_valid[l]),
			.i_en    (i_en),
			.i_cmd   (i_cmd),
			.i_data  (lane_psum[l]),
			.o_valid (lane_out_valid[l]),
			.o_data  (o_qdata[l])
		);

	end

	//////////////////////////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////////////////////////

	// all lanes run in lockstep so lane 0 speaks for the array
	assign o_valid = lane_out_valid[0];

endmodule

/* verification/requant_sva.sv */
`timescale 1ns/1ns

module requant_sva (
	input  logic             clk,
	input  logic             i_rst_n,
	input  logic             i_valid,
	input  logic             i_en,
	input  logic             o_valid,
	input  quant_pkg::qout_t o_data
);

	// first cycle out of reset stays quiet
	a_reset_quiet: assert property (@(posedge clk) !i_rst_n |=> !o_valid)
		else $error("o_valid high in the cycle after reset");

	// a result needs a valid sum and the enable one cycle before
	a_valid_cause: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid |-> $past(i_valid) && $past(i_en))
		else $error("o_valid without input valid and enable one cycle earlier");

	a_zero_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
		!o_valid |-> o_data == '0)  // zero when idle
		else $error("o_data is not zero while o_valid is low");

endmodule

bind bit_select_32x16 requant_sva u_sva (
	.clk     (clk),
	.i_rst_n (i_rst_n),
	.i_valid (i_valid),
	.i_en    (i_en),
	.o_valid (o_valid),
	.o_data  (o_data)
);

/* verification/requant_checker.sv */
`timescale 1ns/1ns

module requant_checker #(
	parameter int LANES = 4
) (
	input  logic                            clk,
	input  logic                            i_rst_n,
	input  logic                            i_valid,
	input  logic                            i_last,
	input  quant_pkg::lane_in_t [LANES-1:0] i_lane_data,
	input  logic                            i_en,
	input  quant_pkg::sel_cmd_t             i_cmd,
	input  logic                            o_valid,
	input  quant_pkg::qout_t [LANES-1:0]    o_qdata,
	output int                              o_err_count,
	output int                              o_result_count,
	output logic                            o_busy      // results still in flight
);

	import quant_pkg::*;

	int    acc [LANES];        // running sums of the model
	int    closed [LANES];     // sums waiting for the selector
	logic  closed_valid = 1'b0;
	qout_t expect_q [LANES];   // due in the next cycle
	logic  expect_valid = 1'b0;
	logic  reset_seen = 1'b0;
	int    errors = 0;
	int    results = 0;

	assign o_err_count    = errors;
	assign o_result_count = results;
	assign o_busy         = closed_valid | expect_valid;

	// low half or 16 bits from offset shift_amt + 1
	function automatic qout_t select_bits(input int sum, input sel_cmd_t cmd);
		logic [31:0] word;
		word = sum;
		if (cmd.shift_en)
			word = word >> (cmd.shift_amt + 1);
		return word[15:0];
	endfunction

	always @(posedge clk)
	begin
		if (!i_rst_n)
			reset_seen <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// compare and then step the model at each falling edge
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		int    a_val;
		int    w_val;
		int    sum;
		qout_t want;
		if (reset_seen)
		begin
			if (o_valid !== expect_valid)
			begin
				errors++;
				if (expect_valid)
					$display("missing o_valid at %0t ns, a result was due", $time);
				else
					$display("unexpected o_valid at %0t ns, no result was due", $time);
			end
			for (int l = 0; l < LANES; l++)
			begin
				want = expect_valid ? expect_q[l] : '0;
				if (o_qdata[l] !== want)
				begin
					errors++;
					$display("Mismatch at %0t ns: o_qdata[%0d] expected 0x%04h got 0x%04h",
						$time, l, want, o_qdata[l]);
				end
			end
			if (expect_valid && o_valid === 1'b1)
				results++;
		end

		if (!i_rst_n)
		begin
			closed_valid = 1'b0;
			expect_valid = 1'b0;
			for (int l = 0; l < LANES; l++)
				acc[l] = 0;
		end
		else
		begin
			// selector stage sees enable and command one cycle after the last beat
			expect_valid = closed_valid && i_en;
			for (int l = 0; l < LANES; l++)
				expect_q[l] = select_bits(closed[l], i_cmd);
			closed_valid = i_valid && i_last;
			for (int l = 0; l < LANES; l++)
			begin
				if (i_valid)
				begin
					a_val = int'($signed(i_lane_data[l].act));
					w_val = int'($signed(i_lane_data[l].wgt));
					sum   = acc[l] + a_val * w_val;  // wraps at 32 bits
					if (i_last)
					begin
						closed[l] = sum;
						acc[l]    = 0;
					end
					else
						acc[l] = sum;
				end
			end
		end
	end

endmodule

/* verification/requant_tb.sv */
`timescale 1ns/1ns

module requant_tb;

	import quant_pkg::*;

	localparam int LANES       = 4;
	localparam int HALF_PERIOD = 50;
	localparam int DRIVE_DELAY = 10;  // after the rising edge
	localparam int WAIT_LIMIT  = 40;  // cycles

	logic                 clk;
	logic                 i_rst_n;
	logic                 i_valid;
	logic                 i_last;
	lane_in_t [LANES-1:0] i_lane_data;
	logic                 i_en;
	sel_cmd_t             i_cmd;
	logic                 o_valid;
	qout_t [LANES-1:0]    o_qdata;

	int          err_count;
	int          result_count;
	logic        model_busy;
	logic [31:0] lfsr = 32'h7916_5415;
	int          timeouts = 0;
	int          last_errs = 0;
	int          last_results = 0;

	requant_top #(.LANES(LANES)) dut (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_valid     (i_valid),
		.i_last      (i_last),
		.i_lane_data (i_lane_data),
		.i_en        (i_en),
		.i_cmd       (i_cmd),
		.o_valid     (o_valid),
		.o_qdata     (o_qdata)
	);

	requant_checker #(.LANES(LANES)) u_checker (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_valid        (i_valid),
		.i_last         (i_last),
		.i_lane_data    (i_lane_data),
		.i_en           (i_en),
		.i_cmd          (i_cmd),
		.o_valid        (o_valid),
		.o_qdata        (o_qdata),
		.o_err_count    (err_count),
		.o_result_count (result_count),
		.o_busy         (model_busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic drive_beat(input logic last);
		logic [31:0] r;
		i_valid = 1'b1;
		i_last  = last;
		for (int l = 0; l < LANES; l++)
		begin
			r = rand_bits(16);
			i_lane_data[l].act = r[15:8];
			i_lane_data[l].wgt = r[7:0];
		end
		next_cycle();
	endtask

	task automatic dot_product(input int beats);
		for (int b = 0; b < beats; b++)
			drive_beat(b == beats - 1);
	endtask

	task automatic idle(input int cycles);
		i_valid = 1'b0;
		i_last  = 1'b0;
		for (int c = 0; c < cycles; c++)
			next_cycle();
	endtask

	task automatic wait_result();
		int n;
		n = 0;
		while (!o_valid && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (!o_valid)
		begin
			timeouts++;
			$display("no o_valid within %0d cycles at %0t ns", WAIT_LIMIT, $time);
		end
	endtask

	// until the model holds nothing in flight and then one quiet cycle
	task automatic drain();
		int n;
		n = 0;
		while (model_busy && n < WAIT_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (model_busy)
		begin
			timeouts++;
			$display("results still pending after %0d cycles at %0t ns", WAIT_LIMIT, $time);
		end
		next_cycle();
	endtask

	// random length 1 to 8 followed by a random gap
	task automatic run_and_wait();
		logic [31:0] r;
		r = rand_bits(3);
		dot_product(int'(r[2:0]) + 1);
		idle(0);
		wait_result();
		r = rand_bits(2);
		idle(int'(r[1:0]) + 1);
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d results, %0d errors", name,
			result_count - last_results, err_count - last_errs);
		last_results = result_count;
		last_errs    = err_count;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] r;
		logic [3:0]  base;
		i_rst_n     = 1'b0;
		i_valid     = 1'b0;
		i_last      = 1'b0;
		i_lane_data = '0;
		i_en        = 1'b0;
		i_cmd       = '0;

		for (int c = 0; c < 16; c++)
			@(posedge clk);
		#DRIVE_DELAY;
		i_rst_n = 1'b1;
		idle(3);
		report_test("reset state");

		i_en = 1'b1;
		for (int k = 0; k < 16; k++)
			run_and_wait();
		report_test("plain selection");

		// two sweeps over all 16 offsets from random starting points
		base = '0;
		for (int k = 0; k < 32; k++)
		begin
			if (k == 0 || k == 16)
			begin
				r    = rand_bits(4);
				base = r[3:0];
			end
			i_cmd.shift_en  = 1'b1;
			i_cmd.shift_amt = base + k[3:0];
			run_and_wait();
		end
		report_test("shifted selection");

		for (int k = 0; k < 12; k++)
		begin
			r     = rand_bits(5);
			i_cmd = r[4:0];
			r     = rand_bits(1);
			i_en  = (k == 0) ? 1'b0 : r[0];
			r     = rand_bits(3);
			dot_product(int'(r[2:0]) + 1);
			idle(0);
			if (i_en)
				wait_result();
			else
				drain();
			idle(1);
		end
		i_en = 1'b1;
		report_test("enable gating");

		r     = rand_bits(5);
		i_cmd = r[4:0];
		for (int k = 0; k < 24; k++)
		begin
			r = rand_bits(2);
			dot_product(r[1] ? 1 : int'(r[0]) + 2);  // half of them single beat
		end
		idle(0);
		drain();
		report_test("back-to-back");

		$display("%0d results checked, %0d errors, %0d timeouts",
			result_count, err_count, timeouts);
		if (err_count == 0 && timeouts == 0 && result_count > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* tb.f */
common/quant_pkg.sv
verilog/mac_lane.sv
bit_select/bit_select_32x16.sv
verilog/requant_top.sv
verification/requant_sva.sv
verification/requant_checker.sv
verification/requant_tb.sv

/* Makefile */
TOP := requant_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
